/* flist.f */
+incdir+common
common/rpRegPkg.sv
common/rpErrPkg.sv
rper1/rpEr1.sv
rper1/rpAccess.sv
hdl/rpFunc.sv
hdl/rpDrive.sv
sim/rpDrive_assertions.sv
sim/rpDriveTb.sv

/* sim/rpDriveTb.sv */
`timescale 1ns/10ps

`include "rp_defs.svh"

module rpDriveTb;

   localparam int NumTests = 5;

   logic        clk;
   logic        rst;
   logic        wr;
   logic [4:0]  addr;
   logic [15:0] dataIn;
   logic [15:0] dataOut;
   logic        unsafe;
   logic        parityErr;
   logic        dataCheck;
   logic        attn;

   // Shadow registers of the reference model
   logic [15:0] mEr1;
   logic [15:0] mDa;
   logic [15:0] mDc;
   logic [4:0]  mFunc;
   logic        mAta;
   int          mCnt;

   int          errCount;
   int          testFails;
   int          testStart;
   int          lowCycles;
   bit          checkEn;
   logic [31:0] rnd;

   rpDrive dut_i
   (
      .clk       (clk),
      .rst       (rst),
      .wr        (wr),
      .addr      (addr),
      .dataIn    (dataIn),
      .dataOut   (dataOut),
      .unsafe    (unsafe),
      .parityErr (parityErr),
      .dataCheck (dataCheck),
      .attn      (attn)
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // One clock of the drive from the state before the edge
   function automatic void rpModel(input logic w, input logic [4:0] a, input logic [15:0] d,
                                   input logic u, input logic p, input logic c);
      logic [15:0] setBits;
      logic [4:0]  f;
      logic        clr;
      logic        ldE;
      logic        ldA;
      logic        ldC;
      logic        go;
      logic        done;
      logic        inPack;
      setBits = '0;
      f = d[5:1];
      clr = 1'b0;
      ldE = 1'b0;
      ldA = 1'b0;
      ldC = 1'b0;
      go = 1'b0;
      done = (mCnt == 1);
      inPack = (mDa[4:0] < `RP_SECTORS) && (mDa[12:8] < `RP_TRACKS) && (mDc[9:0] < `RP_CYLS);
      if (w)
      begin
         if (!(a inside {5'd0, 5'd1, 5'd2, 5'd5, 5'd10}))
            setBits[rpErrPkg::ER1_ILR] = 1'b1;
         else if (a == rpRegPkg::ADDR_CS1 && d[0] && f == rpRegPkg::FUNC_DRVCLR)
            clr = 1'b1;
         else if (mCnt != 0)
            setBits[rpErrPkg::ER1_RMR] = 1'b1;
         else if (a == rpRegPkg::ADDR_ER1)
            ldE = 1'b1;
         else if (a == rpRegPkg::ADDR_DA)
            ldA = 1'b1;
         else if (a == rpRegPkg::ADDR_DC)
            ldC = 1'b1;
         else if (a == rpRegPkg::ADDR_CS1 && d[0])
         begin
            // Codes 2 and 12 need a target inside the pack
            if (f == rpRegPkg::FUNC_RECAL)
               go = 1'b1;
            else if (f == rpRegPkg::FUNC_SEEK || f == rpRegPkg::FUNC_SEARCH)
               if (inPack)
                  go = 1'b1;
               else
                  setBits[rpErrPkg::ER1_IAE] = 1'b1;
            else if (f != rpRegPkg::FUNC_NOP)
               setBits[rpErrPkg::ER1_ILF] = 1'b1;
         end
      end
      setBits[rpErrPkg::ER1_DCK] = c;
      setBits[rpErrPkg::ER1_UNS] = u;
      setBits[rpErrPkg::ER1_PAR] = p;
      // Clear over set over write for every bit
      mEr1 = clr ? 16'h0000 : (setBits | (ldE ? d : mEr1));
      if (clr)
         mAta = 1'b0;
      else if (done || setBits != 0)
         mAta = 1'b1;
      if (done && mFunc == rpRegPkg::FUNC_RECAL)
         mDc = '0;
      else if (ldC)
         mDc = d & 16'h03ff;
      if (ldA)
         mDa = d & 16'h1f1f;
      if (clr)
      begin
         mCnt = 0;
         mFunc = '0;
      end
      else if (go)
      begin
         mCnt = `RP_SEEK_CYCLES;
         mFunc = f;
      end
      else if (mCnt != 0)
         mCnt--;
   endfunction

   function automatic logic [15:0] expRead(input logic [4:0] a);
      case (a)
         rpRegPkg::ADDR_CS1: return {10'b0, mFunc, mCnt != 0};
         rpRegPkg::ADDR_DS:  return {mAta, |mEr1, 6'b0, mCnt == 0, 7'b0};
         rpRegPkg::ADDR_ER1: return mEr1;
         rpRegPkg::ADDR_DA:  return mDa;
         rpRegPkg::ADDR_DC:  return mDc;
         default:            return 16'h0000;
      endcase
   endfunction

   function automatic string regName(input logic [4:0] a);
      case (a)
         rpRegPkg::ADDR_CS1: return "CS1";
         rpRegPkg::ADDR_DS:  return "DS";
         rpRegPkg::ADDR_ER1: return "ER1";
         rpRegPkg::ADDR_DA:  return "DA";
         rpRegPkg::ADDR_DC:  return "DC";
         default:            return "unmapped";
      endcase
   endfunction

   // Model follows the same edges as the DUT
   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mEr1 = '0;
         mDa = '0;
         mDc = '0;
         mFunc = '0;
         mAta = 1'b0;
         mCnt = 0;
      end
      else
         rpModel(wr, addr, dataIn, unsafe, parityErr, dataCheck);
   end

   // Compare on the falling edge once outputs have settled
   always @(negedge clk)
   begin
      if (checkEn)
      begin
         if (dataOut !== expRead(addr))
         begin
            $display("Mismatch %s: got %h expected %h", regName(addr), dataOut, expRead(addr));
            errCount++;
         end
         if (attn !== mAta)
         begin
            $display("Mismatch attn: got %h expected %h", attn, mAta);
            errCount++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   // One host cycle with faults packed as {unsafe, parityErr, dataCheck}
   task automatic drive(input logic w, input logic [4:0] a, input logic [15:0] d,
                        input logic [2:0] flt);
      @(posedge clk);
      wr <= w;
      addr <= a;
      dataIn <= d;
      {unsafe, parityErr, dataCheck} <= flt;
      @(negedge clk);
   endtask

   task automatic read(input logic [4:0] a);
      drive(1'b0, a, 16'h0000, 3'b000);
   endtask

   task automatic readAll();
      read(rpRegPkg::ADDR_CS1);
      read(rpRegPkg::ADDR_DS);
      read(rpRegPkg::ADDR_ER1);
      read(rpRegPkg::ADDR_DA);
      read(rpRegPkg::ADDR_DC);
   endtask

   task automatic driveClear();
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0009, 3'b000);
      read(rpRegPkg::ADDR_DS);
   endtask

   // Poll DS until ATA and count the clocks with DRY low
   task automatic waitAttn(output int lowCnt);
      bit seen;
      lowCnt = 0;
      seen = 0;
      for (int i = 0; i < 4 * `RP_SEEK_CYCLES && !seen; i++)
      begin
         read(rpRegPkg::ADDR_DS);
         if (dataOut[rpErrPkg::DS_ATA])
            seen = 1;
         else if (!dataOut[rpErrPkg::DS_DRY])
            lowCnt++;
      end
      if (!seen)
      begin
         $display("Attention was never raised after the function started");
         errCount++;
      end
   endtask

   task automatic checkErr(input int bitIdx, input string name);
      read(rpRegPkg::ADDR_ER1);
      if (!dataOut[bitIdx])
      begin
         $display("ER1 bit %s was not set", name);
         errCount++;
      end
      read(rpRegPkg::ADDR_DS);
      if (!dataOut[rpErrPkg::DS_ATA])
      begin
         $display("ATA was not raised after %s", name);
         errCount++;
      end
   endtask

   task automatic endTest(input string name);
      if (errCount == testStart)
         $display("%s: pass", name);
      else
      begin
         $display("%s: fail, %0d errors", name, errCount - testStart);
         testFails++;
      end
      testStart = errCount;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      wr = 1'b0;
      addr = '0;
      dataIn = '0;
      unsafe = 1'b0;
      parityErr = 1'b0;
      dataCheck = 1'b0;
      errCount = 0;
      testFails = 0;
      checkEn = 0;
      rnd = 32'he175;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      checkEn <= 1'b1;
      testStart = 0;

      readAll();
      read(rpRegPkg::ADDR_DS);
      if (dataOut !== 16'h0080)
      begin
         $display("Mismatch DS: got %h expected %h", dataOut, 16'h0080);
         errCount++;
      end
      endTest("reset state");

      for (int n = 0; n < 8; n++)
      begin
         rnd = xorshift(rnd);
         drive(1'b1, rpRegPkg::ADDR_DA, rnd[15:0], 3'b000);
         drive(1'b1, rpRegPkg::ADDR_DC, rnd[31:16], 3'b000);
         rnd = xorshift(rnd);
         drive(1'b1, rpRegPkg::ADDR_ER1, rnd[15:0], 3'b000);
         readAll();
      end
      endTest("register readback");

      // SEEK to sector 5 track 3 cylinder 100
      driveClear();
      drive(1'b1, rpRegPkg::ADDR_DA, 16'h0305, 3'b000);
      drive(1'b1, rpRegPkg::ADDR_DC, 16'd100, 3'b000);
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0005, 3'b000);
      waitAttn(lowCycles);
      if (lowCycles != `RP_SEEK_CYCLES)
      begin
         $display("Mismatch DRY low cycles: got %h expected %h", lowCycles, `RP_SEEK_CYCLES);
         errCount++;
      end
      read(rpRegPkg::ADDR_CS1);
      if (dataOut !== 16'h0004)
      begin
         $display("Mismatch CS1: got %h expected %h", dataOut, 16'h0004);
         errCount++;
      end
      driveClear();
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0007, 3'b000);
      waitAttn(lowCycles);
      read(rpRegPkg::ADDR_DC);
      if (dataOut !== 16'h0000)
      begin
         $display("Mismatch DC: got %h expected %h", dataOut, 16'h0000);
         errCount++;
      end
      endTest("seek timing");

      driveClear();
      drive(1'b1, 5'd7, 16'hffff, 3'b000);
      checkErr(rpErrPkg::ER1_ILR, "ILR");
      driveClear();
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0003, 3'b000);
      checkErr(rpErrPkg::ER1_ILF, "ILF");
      // Sector 25 is off the track
      driveClear();
      drive(1'b1, rpRegPkg::ADDR_DA, 16'h0019, 3'b000);
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0005, 3'b000);
      read(rpRegPkg::ADDR_DS);
      if (!dataOut[rpErrPkg::DS_DRY])
      begin
         $display("Drive went busy on a SEEK outside the pack");
         errCount++;
      end
      checkErr(rpErrPkg::ER1_IAE, "IAE");
      driveClear();
      drive(1'b1, rpRegPkg::ADDR_DA, 16'h0305, 3'b000);
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0005, 3'b000);
      drive(1'b1, rpRegPkg::ADDR_DA, 16'h0102, 3'b000);
      read(rpRegPkg::ADDR_DA);
      if (dataOut !== 16'h0305)
      begin
         $display("Mismatch DA: got %h expected %h", dataOut, 16'h0305);
         errCount++;
      end
      checkErr(rpErrPkg::ER1_RMR, "RMR");
      endTest("access errors");

      driveClear();
      drive(1'b0, rpRegPkg::ADDR_ER1, 16'h0000, 3'b010);
      drive(1'b0, rpRegPkg::ADDR_ER1, 16'h0000, 3'b001);
      drive(1'b0, rpRegPkg::ADDR_ER1, 16'h0000, 3'b100);
      read(rpRegPkg::ADDR_ER1);
      if ((dataOut & 16'hc008) !== 16'hc008)
      begin
         $display("Mismatch ER1 fault bits: got %h expected %h", dataOut & 16'hc008, 16'hc008);
         errCount++;
      end
      // Drive clear aborts a seek in flight with faults and ATA pending
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0005, 3'b000);
      read(rpRegPkg::ADDR_DS);
      driveClear();
      if (dataOut !== 16'h0080)
      begin
         $display("Mismatch DS: got %h expected %h", dataOut, 16'h0080);
         errCount++;
      end
      drive(1'b1, rpRegPkg::ADDR_CS1, 16'h0009, 3'b010);
      read(rpRegPkg::ADDR_ER1);
      if (dataOut !== 16'h0000)
      begin
         $display("Mismatch ER1: got %h expected %h", dataOut, 16'h0000);
         errCount++;
      end
      endTest("faults and drive clear");

      $display("%0d tests passed, %0d tests failed, %0d errors",
               NumTests - testFails, testFails, errCount);
      if (errCount == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // Run limit scaled from the test count and seek time
   initial
   begin
      #((NumTests * 64 + 2 * `RP_SEEK_CYCLES) * 8 * 4);
      $display("Watchdog expired before the tests completed");
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* sim/rpDrive_assertions.sv */
`timescale 1ns/10ps

`include "rp_defs.svh"

module rpDriveAssertions
(
   input logic        clk,
   input logic        rst,
   input logic        wr,
   input logic [4:0]  addr,
   input logic [15:0] dataIn,
   input logic [15:0] dataOut,
   input logic        busy,
   input logic        attn,
   input logic [15:0] ds,
   input logic [15:0] er1
);

   // Drive leaves reset ready
   dryAfterReset: assert property (@(posedge clk) $fell(rst) |-> ds[rpErrPkg::DS_DRY])
      else $error("DRY low on the first clock after reset");

   // Positioning never outlasts the seek time
   busyBounded: assert property (@(posedge clk) disable iff (rst)
      $rose(busy) |-> ##[1:`RP_SEEK_CYCLES] !busy)
      else $error("busy held longer than the seek time");

   // Host view of DS agrees with the attention line
   attnIsAta: assert property (@(posedge clk) disable iff (rst)
      (addr == rpRegPkg::ADDR_DS) |-> attn == dataOut[rpErrPkg::DS_ATA])
      else $error("attn differs from DS ATA");

   // Undefined function code with GO while the drive is idle
   illegalFuncSetsIlf: assert property (@(posedge clk) disable iff (rst)
      (wr && !busy && addr == rpRegPkg::ADDR_CS1 && `RP_CS1_GO(dataIn) &&
       !(`RP_CS1_FUNC(dataIn) inside {rpRegPkg::FUNC_NOP, rpRegPkg::FUNC_SEEK,
         rpRegPkg::FUNC_RECAL, rpRegPkg::FUNC_DRVCLR, rpRegPkg::FUNC_SEARCH}))
      |=> er1[rpErrPkg::ER1_ILF])
      else $error("illegal function did not set ILF");

endmodule

bind rpDrive rpDriveAssertions uAssert (.*);

/* hdl/rpDrive.sv */
`timescale 1ns/10ps

`include "rp_defs.svh"

module rpDrive
(
   input  logic        clk,
   input  logic        rst,
   // Host register port
   input  logic        wr,
   input  logic [4:0]  addr,
   input  logic [15:0] dataIn,
   output logic [15:0] dataOut,
   // Drive faults
   input  logic        unsafe,
   input  logic        parityErr,
   input  logic        dataCheck,
   output logic        attn
);

   // Strobes from the access checker
   logic ldEr1;
   logic ldDa;
   logic ldDc;
   logic start;
   logic drvClr;
   logic setIlr;
   logic setIlf;
   logic setRmr;
   logic setIae;
   rpRegPkg::rpFuncT startFunc;

   // Function state
   logic busy;
   logic ata;
   logic recalDone;
   rpRegPkg::rpFuncT curFunc;

   // Error register
   logic [15:0] er1;
   logic        errEvent;

   // Registers held here
   logic [15:0] daReg;
   logic [15:0] dcReg;
   logic [15:0] cs1;
   logic [15:0] ds;

   //////////////////////////////////////////////////////////////////////
   // Submodules
   //////////////////////////////////////////////////////////////////////

   rpAccess uAccess
   (
      .wr        (wr),
      .addr      (addr),
      .dataIn    (dataIn),
      .busy      (busy),
      .daReg     (daReg),
      .dcReg     (dcReg),
      .ldEr1     (ldEr1),
      .ldDa      (ldDa),
      .ldDc      (ldDc),
      .start     (start),
      .startFunc (startFunc),
      .drvClr    (drvClr),
      .setIlr    (setIlr),
      .setIlf    (setIlf),
      .setRmr    (setRmr),
      .setIae    (setIae)
   );

   // Faults go straight to their ER1 set inputs
   rpEr1 uEr1
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (drvClr),
      .setDck   (dataCheck),
      .setUns   (unsafe),
      .setPar   (parityErr),
      .setRmr   (setRmr),
      .setIlr   (setIlr),
      .setIlf   (setIlf),
      .setIae   (setIae),
      .dataIn   (dataIn),
      .ldEr1    (ldEr1),
      .er1      (er1),
      .errEvent (errEvent)
   );

   rpFunc uFunc
   (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .startFunc (startFunc),
      .drvClr    (drvClr),
      .errEvent  (errEvent),
      .busy      (busy),
      .curFunc   (curFunc),
      .ata       (ata),
      .recalDone (recalDone)
   );

   //////////////////////////////////////////////////////////////////////
   // Desired Address and Desired Cylinder
   //////////////////////////////////////////////////////////////////////

   // Only the sector and track fields are kept
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         daReg <= '0;
      else if (ldDa)
         daReg <= {3'b000, `RP_DA_TRK(dataIn), 3'b000, `RP_DA_SECT(dataIn)};
   end

   // RECAL parks the heads at cylinder 0
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dcReg <= '0;
      else if (recalDone)
         dcReg <= '0;
      else if (ldDc)
         dcReg <= {6'b000000, `RP_DC_CYL(dataIn)};
   end

   //////////////////////////////////////////////////////////////////////
   // Status assembly and readback
   //////////////////////////////////////////////////////////////////////

   // GO reads back as busy
   assign cs1 = {10'b0, curFunc, busy};

   always_comb
   begin
      ds = '0;
      ds[rpErrPkg::DS_ATA] = ata;
      // Summary of every ER1 bit
      ds[rpErrPkg::DS_ERR] = |er1;
      ds[rpErrPkg::DS_DRY] = ~busy;
   end

   assign attn = ds[rpErrPkg::DS_ATA];

   // Reads are side-effect free
   always_comb
   begin
      case (addr)
         rpRegPkg::ADDR_CS1: dataOut = cs1;
         rpRegPkg::ADDR_DS:  dataOut = ds;
         rpRegPkg::ADDR_ER1: dataOut = er1;
         rpRegPkg::ADDR_DA:  dataOut = daReg;
         rpRegPkg::ADDR_DC:  dataOut = dcReg;
         default:            dataOut = '0;
      endcase
   end

endmodule

/* hdl/rpFunc.sv */
`timescale 1ns/10ps

`include "rp_defs.svh"

module rpFunc
(
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  rpRegPkg::rpFuncT  startFunc,
   input  logic              drvClr,
   input  logic              errEvent,
   output logic              busy,
   output rpRegPkg::rpFuncT  curFunc,
   output logic              ata,
   output logic              recalDone
);

   localparam int CntW = $clog2(`RP_SEEK_CYCLES + 1);

   // Clocks of positioning left
   logic [CntW-1:0] cnt;
   // Last busy clock, busy drops on the next edge
   logic            done;

   assign busy      = (cnt != '0);
   assign done      = (cnt == CntW'(1));
   assign recalDone = done && (curFunc == rpRegPkg::FUNC_RECAL);

   //////////////////////////////////////////////////////////////////////
   // Function latch and seek timer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cnt     <= '0;
         curFunc <= rpRegPkg::FUNC_NOP;
      end
      else if (drvClr)
      begin
         // Abort any motion in progress
         cnt     <= '0;
         curFunc <= rpRegPkg::FUNC_NOP;
      end
      else if (start)
      begin
         cnt     <= CntW'(`RP_SEEK_CYCLES);
         curFunc <= startFunc;
      end
      else if (busy)
         cnt <= cnt - CntW'(1);
   end

   //////////////////////////////////////////////////////////////////////
   // Attention
   //////////////////////////////////////////////////////////////////////

   // Raised by completion or any error, dropped only by drive clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (drvClr)
         ata <= 1'b0;
      else if (done || errEvent)
         ata <= 1'b1;
   end

endmodule

/* rper1/rpAccess.sv */
`timescale 1ns/10ps

`include "rp_defs.svh"

module rpAccess
(
   input  logic              wr,
   input  logic [4:0]        addr,
   input  logic [15:0]       dataIn,
   input  logic              busy,
   input  logic [15:0]       daReg,
   input  logic [15:0]       dcReg,
   output logic              ldEr1,
   output logic              ldDa,
   output logic              ldDc,
   output logic              start,
   output rpRegPkg::rpFuncT  startFunc,
   output logic              drvClr,
   output logic              setIlr,
   output logic              setIlf,
   output logic              setRmr,
   output logic              setIae
);

   // Fields of the word being written to CS1
   logic [4:0] fn;
   logic       go;
   // Current DA and DC lie inside the pack
   logic       geomOk;
   // Register select hits a real register
   logic       mapped;

   assign fn = `RP_CS1_FUNC(dataIn);
   assign go = `RP_CS1_GO(dataIn);

   assign geomOk = (`RP_DA_SECT(daReg) < `RP_SECTORS) &&
                   (`RP_DA_TRK(daReg) < `RP_TRACKS) &&
                   (`RP_DC_CYL(dcReg) < `RP_CYLS);

   assign mapped = (addr == rpRegPkg::ADDR_CS1) || (addr == rpRegPkg::ADDR_DS) ||
                   (addr == rpRegPkg::ADDR_ER1) || (addr == rpRegPkg::ADDR_DA) ||
                   (addr == rpRegPkg::ADDR_DC);

   //////////////////////////////////////////////////////////////////////
   // Write decode and checks
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ldEr1     = 1'b0;
      ldDa      = 1'b0;
      ldDc      = 1'b0;
      start     = 1'b0;
      startFunc = rpRegPkg::rpFuncT'(fn);
      drvClr    = 1'b0;
      setIlr    = 1'b0;
      setIlf    = 1'b0;
      setRmr    = 1'b0;
      setIae    = 1'b0;

      if (wr)
      begin
         if (!mapped)
            setIlr = 1'b1;
         // Drive clear gets through even mid-seek
         else if (addr == rpRegPkg::ADDR_CS1 && go && fn == rpRegPkg::FUNC_DRVCLR)
            drvClr = 1'b1;
         // Any other write while busy is refused
         else if (busy)
            setRmr = 1'b1;
         else
         begin
            case (addr)
               rpRegPkg::ADDR_ER1: ldEr1 = 1'b1;
               rpRegPkg::ADDR_DA:  ldDa  = 1'b1;
               rpRegPkg::ADDR_DC:  ldDc  = 1'b1;
               rpRegPkg::ADDR_CS1:
               begin
                  // GO clear is a no-op
                  if (go)
                  begin
                     case (fn)
                        rpRegPkg::FUNC_NOP:
                        begin
                        end
                        rpRegPkg::FUNC_RECAL:
                           start = 1'b1;
                        rpRegPkg::FUNC_SEEK, rpRegPkg::FUNC_SEARCH:
                        begin
                           // Off the pack: flag IAE, no motion
                           if (geomOk)
                              start = 1'b1;
                           else
                              setIae = 1'b1;
                        end
                        default:
                           setIlf = 1'b1;
                     endcase
                  end
               end
               // DS is read only
               default:
               begin
               end
            endcase
         end
      end
   end

endmodule

/* rper1/rpEr1.sv */
`timescale 1ns/10ps

module rpEr1
(
   input  logic        clk,
   input  logic        rst,
   // Drive clear
   input  logic        clr,
   input  logic        setDck,
   input  logic        setUns,
   input  logic        setPar,
   input  logic        setRmr,
   input  logic        setIlr,
   input  logic        setIlf,
   input  logic        setIae,
   input  logic [15:0] dataIn,
   input  logic        ldEr1,
   output logic [15:0] er1,
   output logic        errEvent
);

   //////////////////////////////////////////////////////////////////////
   // Set pulses gathered into register order
   //////////////////////////////////////////////////////////////////////

   logic [15:0] setVec;

   always_comb
   begin
      setVec = '0;
      // Faults from the drive electronics
      setVec[rpErrPkg::ER1_DCK] = setDck;
      setVec[rpErrPkg::ER1_UNS] = setUns;
      setVec[rpErrPkg::ER1_PAR] = setPar;
      // Host access errors
      setVec[rpErrPkg::ER1_IAE] = setIae;
      setVec[rpErrPkg::ER1_RMR] = setRmr;
      setVec[rpErrPkg::ER1_ILR] = setIlr;
      setVec[rpErrPkg::ER1_ILF] = setIlf;
      // IOP, DTE, WLE, AOE, HCRC, HCE, ECH, WCF, FER stay at zero
      // Those bits move only on clear and host write
   end

   // Any error source firing this clock
   assign errEvent = |setVec;

   //////////////////////////////////////////////////////////////////////
   // Error flops
   //////////////////////////////////////////////////////////////////////

   // Per bit: clear beats set, set beats host write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else if (clr)
         er1 <= '0;
      else
      begin
         for (int i = 0; i < 16; i++)
         begin
            if (setVec[i])
               er1[i] <= 1'b1;
            else if (ldEr1)
               er1[i] <= dataIn[i];
         end
      end
   end

endmodule

/* common/rpErrPkg.sv */
package rpErrPkg;

   // Error Register #1 bit positions
   typedef enum logic [3:0]
   {
      ER1_ILF  = 4'd0,
      ER1_ILR  = 4'd1,
      ER1_RMR  = 4'd2,
      ER1_PAR  = 4'd3,
      ER1_FER  = 4'd4,
      ER1_WCF  = 4'd5,
      ER1_ECH  = 4'd6,
      ER1_HCE  = 4'd7,
      ER1_HCRC = 4'd8,
      ER1_AOE  = 4'd9,
      ER1_IAE  = 4'd10,
      ER1_WLE  = 4'd11,
      ER1_DTE  = 4'd12,
      ER1_IOP  = 4'd13,
      ER1_UNS  = 4'd14,
      ER1_DCK  = 4'd15
   } er1BitT;

   // Drive Status bits modelled here
   typedef enum logic [3:0]
   {
      DS_DRY = 4'd7,
      DS_ERR = 4'd14,
      DS_ATA = 4'd15
   } dsBitT;

endpackage

/* common/rpRegPkg.sv */
package rpRegPkg;

   //////////////////////////////////////////////////////////////////////
   // Drive register map
   //////////////////////////////////////////////////////////////////////

   // Massbus register select codes
   // Anything not listed is an unmapped register
   typedef enum logic [4:0]
   {
      // Control and Status 1
      ADDR_CS1 = 5'd0,
      // Drive Status
      ADDR_DS  = 5'd1,
      // Error Register #1
      ADDR_ER1 = 5'd2,
      // Desired sector and track
      ADDR_DA  = 5'd5,
      // Desired cylinder
      ADDR_DC  = 5'd10
   } rpAddrT;

   //////////////////////////////////////////////////////////////////////
   // Function codes
   //////////////////////////////////////////////////////////////////////

   // CS1 bits 5:1, every other code is illegal here
   typedef enum logic [4:0]
   {
      FUNC_NOP    = 5'd0,
      FUNC_SEEK   = 5'd2,
      // Return heads to cylinder zero
      FUNC_RECAL  = 5'd3,
      FUNC_DRVCLR = 5'd4,
      FUNC_SEARCH = 5'd12
   } rpFuncT;

endpackage

/* common/rp_defs.svh */
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Drive geometry
//////////////////////////////////////////////////////////////////////

// Sectors per track
`define RP_SECTORS 20
// Tracks (heads) per cylinder
`define RP_TRACKS 19
// Cylinders per pack
`define RP_CYLS 815

// Clocks that SEEK, SEARCH and RECAL hold the drive busy
`define RP_SEEK_CYCLES 12

//////////////////////////////////////////////////////////////////////
// Register field extraction
//////////////////////////////////////////////////////////////////////

// Desired Address sector and track
`define RP_DA_SECT(d) (d[4:0])
`define RP_DA_TRK(d) (d[12:8])

// Desired Cylinder
`define RP_DC_CYL(d) (d[9:0])

// Control and Status 1 function code and GO
`define RP_CS1_FUNC(d) (d[5:1])
`define RP_CS1_GO(d) (d[0])

`endif
